/* Makefile */
VERILATOR := verilator
TOP       := tb_dmem_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --Mdir $(OBJ_DIR) --top-module $(TOP)
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	./$(SIM) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dmem_align_check.sv */
/*
 * data memory alignment and range check, flags bad
 * accesses and gives the word index inside the RAM
 */
`timescale 1ns/1ps

module dmem_align_check #(
    parameter logic [isa_pkg::XLEN-1:0] RAM_BASE   = 64'h8000_0000,
    parameter int                       DEPTH_LOG2 = 8
) (
    input  dmem_pkg::dmem_req_t     req,
    output logic                    err,
    output logic [DEPTH_LOG2-1:0]   word_idx
);

    logic [isa_pkg::XLEN-1:0] rel;
    logic                     misaligned;
    logic                     out_of_range;

    // base-relative byte address, wraps high for addresses below RAM_BASE
    assign rel = req.addr - RAM_BASE;

    // RAM_BASE is word aligned, so the low bits match the raw address
    always_comb begin
        case (req.width)
            isa_pkg::WIDTH_B: misaligned = 1'b0;
            isa_pkg::WIDTH_H: misaligned = rel[0];
            isa_pkg::WIDTH_W: misaligned = |rel[1:0];
            default:          misaligned = |rel[2:0];
        endcase
    end

    // any bit above the RAM size means past the end or below the base
    assign out_of_range = |rel[isa_pkg::XLEN-1:DEPTH_LOG2+3];

    assign err      = misaligned | out_of_range;
    assign word_idx = rel[DEPTH_LOG2+2:3];

endmodule

/* dmem_array.sv */
/*
 * data memory storage, one XLEN word per entry with byte
 * write enables and a read register loaded on re
 */
`timescale 1ns/1ps

module dmem_array #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic                        re,
    input  logic [DEPTH_LOG2-1:0]       widx,
    input  logic [7:0]                  be,
    input  logic [isa_pkg::XLEN-1:0]    wdata,
    output logic [isa_pkg::XLEN-1:0]    rdata
);

    logic [isa_pkg::XLEN-1:0] mem [0:(1 << DEPTH_LOG2)-1];

    // write only the enabled byte lanes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (be[b]) begin
                    mem[widx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // read register holds its value while the response is stalled
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[widx];
        end
    end

    // the response stage accepts one request per cycle, so a load and
    // a store never hit the array in the same cycle
    a_no_rw_overlap: assert property (
        @(posedge clk) !(we && re)
    ) else $error("dmem_array: read and write enabled together");

endmodule

/* dmem_load_extract.sv */
/*
 * load lane selection, picks the addressed bytes out of the
 * read word and zero-extends them to XLEN
 */
`timescale 1ns/1ps

module dmem_load_extract (
    input  logic [isa_pkg::XLEN-1:0]    word,
    input  isa_pkg::mem_width_e         width,
    input  logic [2:0]                  offset,
    output logic [isa_pkg::XLEN-1:0]    data
);

    logic [isa_pkg::XLEN-1:0] shifted;

    // addressed lane moved down to bit 0
    assign shifted = word >> {offset, 3'b000};

    // keep only the access width, upper bits zero
    always_comb begin
        case (width)
            isa_pkg::WIDTH_B: begin
                data = isa_pkg::XLEN'(shifted[7:0]);
            end
            isa_pkg::WIDTH_H: begin
                data = isa_pkg::XLEN'(shifted[15:0]);
            end
            isa_pkg::WIDTH_W: begin
                data = isa_pkg::XLEN'(shifted[31:0]);
            end
            default: begin
                data = shifted;
            end
        endcase
    end

endmodule

/* dmem_pkg.sv */
/*
 * data memory channel types: request, response and the
 * metadata kept for the request in flight
 */
package dmem_pkg;

    // request channel payload
    typedef struct packed {
        isa_pkg::mem_op_e           op;
        isa_pkg::mem_width_e        width;
        logic [isa_pkg::XLEN-1:0]   addr;
        logic [isa_pkg::XLEN-1:0]   wdata;
    } dmem_req_t;

    // response channel payload
    // rdata is zero for stores and for failed accesses
    typedef struct packed {
        isa_pkg::mem_op_e           op;
        logic                       err;
        logic [isa_pkg::XLEN-1:0]   rdata;
    } dmem_rsp_t;

    // what the response stage needs to finish a request
    typedef struct packed {
        isa_pkg::mem_op_e           op;
        isa_pkg::mem_width_e        width;
        logic [2:0]                 offset;
        logic                       err;
    } dmem_meta_t;

endpackage

/* dmem_resp_stage.sv */
/*
 * data memory response stage: accept decision, array enables,
 * in-flight metadata and the response valid/ready channel
 */
`timescale 1ns/1ps

module dmem_resp_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  dmem_pkg::dmem_meta_t        req_meta,
    output logic                        we,
    output logic                        re,
    output dmem_pkg::dmem_meta_t        held_meta,
    input  logic [isa_pkg::XLEN-1:0]    load_data,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output dmem_pkg::dmem_rsp_t         rsp
);

    logic accept;

    // room when nothing is pending or the pending response leaves now
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    // failed stores never reach the array
    assign we = accept && (req_meta.op == isa_pkg::OP_STORE) && !req_meta.err;
    assign re = accept && (req_meta.op == isa_pkg::OP_LOAD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_meta <= req_meta;
        end
    end

    // data only for loads that passed the check
    always_comb begin
        rsp.op  = held_meta.op;
        rsp.err = held_meta.err;
        if (held_meta.op == isa_pkg::OP_LOAD && !held_meta.err) begin
            rsp.rdata = load_data;
        end else begin
            rsp.rdata = '0;
        end
    end

    // a stalled response keeps its payload, including the array read data
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("dmem_resp_stage: response changed while stalled");

endmodule

/* dmem_store_lane.sv */
/*
 * store lane placement: byte enables from width and byte
 * offset, store data moved up into the addressed lanes
 */
`timescale 1ns/1ps

module dmem_store_lane (
    input  dmem_pkg::dmem_req_t         req,
    output logic [7:0]                  be,
    output logic [isa_pkg::XLEN-1:0]    wdata
);

    logic [2:0] offset;
    logic [7:0] base_mask;

    assign offset = req.addr[2:0];

    // lanes covered by the access before shifting
    always_comb begin
        case (req.width)
            isa_pkg::WIDTH_B: base_mask = 8'h01;
            isa_pkg::WIDTH_H: base_mask = 8'h03;
            isa_pkg::WIDTH_W: base_mask = 8'h0f;
            default:          base_mask = 8'hff;
        endcase
    end

    // misaligned stores may spill lanes off the top, they are
    // blocked by the write enable anyway
    assign be = base_mask << offset;

    // low bytes of the store data land at the byte offset
    assign wdata = req.wdata << {offset, 3'b000};

endmodule

/* dmem_top.sv */
/*
 * data memory top level: request check and lane placement,
 * storage, load lane selection and the response stage
 */
`timescale 1ns/1ps

module dmem_top #(
    parameter logic [isa_pkg::XLEN-1:0] RAM_BASE   = 64'h8000_0000,
    parameter int                       DEPTH_LOG2 = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  dmem_pkg::dmem_req_t     req,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output dmem_pkg::dmem_rsp_t     rsp
);

    logic                       chk_err;
    logic [DEPTH_LOG2-1:0]      word_idx;
    logic [7:0]                 be;
    logic [isa_pkg::XLEN-1:0]   lane_wdata;
    logic [isa_pkg::XLEN-1:0]   array_rdata;
    logic [isa_pkg::XLEN-1:0]   load_data;
    logic                       we;
    logic                       re;
    dmem_pkg::dmem_meta_t       req_meta;
    dmem_pkg::dmem_meta_t       held_meta;

    assign req_meta = '{op: req.op, width: req.width, offset: req.addr[2:0], err: chk_err};

    dmem_align_check #(
        .RAM_BASE   (RAM_BASE),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_align_check (
        .req        (req),
        .err        (chk_err),
        .word_idx   (word_idx)
    );

    dmem_store_lane i_store_lane (
        .req    (req),
        .be     (be),
        .wdata  (lane_wdata)
    );

    dmem_array #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_array (
        .clk    (clk),
        .we     (we),
        .re     (re),
        .widx   (word_idx),
        .be     (be),
        .wdata  (lane_wdata),
        .rdata  (array_rdata)
    );

    dmem_load_extract i_load_extract (
        .word   (array_rdata),
        .width  (held_meta.width),
        .offset (held_meta.offset),
        .data   (load_data)
    );

    dmem_resp_stage i_resp_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_meta   (req_meta),
        .we         (we),
        .re         (re),
        .held_meta  (held_meta),
        .load_data  (load_data),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

endmodule

/* isa_pkg.sv */
/*
 * isa definitions shared by the load/store datapath:
 * machine word width, access widths and memory operations
 */
package isa_pkg;

    // machine word and address width
    localparam int XLEN = 64;

    // access width, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        WIDTH_B = 2'd0,
        WIDTH_H = 2'd1,
        WIDTH_W = 2'd2,
        WIDTH_D = 2'd3
    } mem_width_e;

    // memory operation
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

endpackage

/* src.f */
isa_pkg.sv
dmem_pkg.sv
dmem_align_check.sv
dmem_store_lane.sv
dmem_array.sv
dmem_load_extract.sv
dmem_resp_stage.sv
dmem_top.sv
tb_dmem_top.sv

/* tb_dmem_top.sv */
/*
 * directed testbench for the data memory, checks every response
 * against a word-indexed reference model of the RAM
 */
`timescale 1ns/1ps

module tb_dmem_top;

    localparam logic [63:0] RAM_BASE  = 64'h8000_0000;
    localparam logic [63:0] RAM_BYTES = 64'd2048;
    localparam int          TIMEOUT   = 100;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    dmem_pkg::dmem_req_t    req;
    logic                   rsp_valid;
    logic                   rsp_ready;
    dmem_pkg::dmem_rsp_t    rsp;

    // reference memory keyed by word index
    logic [63:0] model [int];
    // toggle rsp_ready while a response waits
    bit          random_ready;

    dmem_top i_dmem_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_rsp(input dmem_pkg::dmem_rsp_t got, input dmem_pkg::dmem_rsp_t want,
                             input string msg);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s, got op %0d err %0b rdata %h", $time, msg,
                     got.op, got.err, got.rdata);
            $display("    expected op %0d err %0b rdata %h", want.op, want.err, want.rdata);
            stop_with_failure();
        end
    endtask

    task automatic check_ready(input logic got, input logic want, input string msg);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, want);
            stop_with_failure();
        end
    endtask

    function automatic int access_bytes(input isa_pkg::mem_width_e width);
        case (width)
            isa_pkg::WIDTH_B: return 1;
            isa_pkg::WIDTH_H: return 2;
            isa_pkg::WIDTH_W: return 4;
            default:          return 8;
        endcase
    endfunction

    function automatic bit access_fails(input dmem_pkg::dmem_req_t r);
        logic [63:0] n;
        n = 64'(access_bytes(r.width));
        if (r.addr % n != 64'd0) return 1'b1;
        if (r.addr < RAM_BASE) return 1'b1;
        return (r.addr - RAM_BASE) >= RAM_BYTES;
    endfunction

    // expected response, and the model update for a good store
    task automatic model_access(input dmem_pkg::dmem_req_t r, output dmem_pkg::dmem_rsp_t want);
        int          idx;
        int          off;
        logic [63:0] word;
        want.op    = r.op;
        want.err   = access_fails(r);
        want.rdata = '0;
        if (!want.err) begin
            idx  = int'((r.addr - RAM_BASE) >> 3);
            off  = int'(r.addr[2:0]);
            word = model.exists(idx) ? model[idx] : 64'd0;
            for (int i = 0; i < access_bytes(r.width); i++) begin
                if (r.op == isa_pkg::OP_STORE) begin
                    word[8*(off+i) +: 8] = r.wdata[8*i +: 8];
                end else begin
                    want.rdata[8*i +: 8] = word[8*(off+i) +: 8];
                end
            end
            if (r.op == isa_pkg::OP_STORE) begin
                model[idx] = word;
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(input dmem_pkg::dmem_req_t r);
        int waited;
        waited    = 0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            if (waited == TIMEOUT) begin
                $display("timeout at %0t: the request was never accepted", $time);
                stop_with_failure();
            end
            waited++;
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        check_ready(rsp_valid, 1'b1, "rsp_valid one cycle after accept");
    endtask

    task automatic get_rsp(output dmem_pkg::dmem_rsp_t got);
        int                  waited;
        bit                  seen;
        dmem_pkg::dmem_rsp_t first;
        waited = 0;
        seen   = 1'b0;
        forever begin
            if (rsp_valid) begin
                if (seen) begin
                    check_rsp(rsp, first, "response held under back-pressure");
                end
                first = rsp;
                seen  = 1'b1;
                if (!rsp_ready) begin
                    check_ready(req_ready, 1'b0, "req_ready while the response stalls");
                end
            end
            if (random_ready) begin
                rsp_ready = 1'($urandom_range(0, 1));
            end
            // taken at the next rising edge
            if (rsp_valid && rsp_ready) break;
            if (waited == TIMEOUT) begin
                $display("timeout at %0t: no response was taken", $time);
                stop_with_failure();
            end
            waited++;
            @(negedge clk);
        end
        got = rsp;
        @(negedge clk);
    endtask

    task automatic run_access(input isa_pkg::mem_op_e op, input isa_pkg::mem_width_e width,
                              input logic [63:0] addr, input logic [63:0] wdata,
                              input string msg);
        dmem_pkg::dmem_req_t r;
        dmem_pkg::dmem_rsp_t want;
        dmem_pkg::dmem_rsp_t got;
        r = '{op: op, width: width, addr: addr, wdata: wdata};
        model_access(r, want);
        send_req(r);
        get_rsp(got);
        check_rsp(got, want, msg);
    endtask

    task automatic reset_test();
        check_ready(rsp_valid, 1'b0, "rsp_valid after reset");
        check_ready(req_ready, 1'b1, "req_ready after reset");
    endtask

    task automatic dword_test();
        int idx [5] = '{0, 1, 2, 7, 255};
        foreach (idx[k]) begin
            run_access(isa_pkg::OP_STORE, isa_pkg::WIDTH_D, RAM_BASE + 64'(idx[k] * 8),
                       {$urandom, $urandom}, "doubleword store");
        end
        foreach (idx[k]) begin
            run_access(isa_pkg::OP_LOAD, isa_pkg::WIDTH_D, RAM_BASE + 64'(idx[k] * 8),
                       64'd0, "doubleword load");
        end
    endtask

    task automatic narrow_test();
        logic [63:0]         a;
        isa_pkg::mem_width_e width;
        a = RAM_BASE + 64'h80;
        run_access(isa_pkg::OP_STORE, isa_pkg::WIDTH_D, a, {$urandom, $urandom}, "word fill");
        for (int w = 0; w < 3; w++) begin
            width = isa_pkg::mem_width_e'(w);
            for (int off = 0; off < 8; off += access_bytes(width)) begin
                run_access(isa_pkg::OP_STORE, width, a + 64'(off), {$urandom, $urandom},
                           "narrow store");
            end
            // every width read back at every aligned offset
            for (int lw = 0; lw < 4; lw++) begin
                for (int off = 0; off < 8; off += access_bytes(isa_pkg::mem_width_e'(lw))) begin
                    run_access(isa_pkg::OP_LOAD, isa_pkg::mem_width_e'(lw), a + 64'(off),
                               64'd0, "narrow load");
                end
            end
        end
    endtask

    task automatic error_test();
        logic [63:0]      a;
        logic [63:0]      d;
        isa_pkg::mem_op_e op;
        a = RAM_BASE + 64'h100;
        d = {$urandom, $urandom};
        run_access(isa_pkg::OP_STORE, isa_pkg::WIDTH_D, a, d, "word fill");
        for (int k = 0; k < 2; k++) begin
            op = isa_pkg::mem_op_e'(k);
            run_access(op, isa_pkg::WIDTH_H, a + 64'd1, ~d, "misaligned halfword");
            run_access(op, isa_pkg::WIDTH_W, a + 64'd2, ~d, "misaligned word");
            run_access(op, isa_pkg::WIDTH_D, a + 64'd4, ~d, "misaligned doubleword");
            run_access(op, isa_pkg::WIDTH_D, RAM_BASE - 64'd8, ~d, "below RAM_BASE");
            run_access(op, isa_pkg::WIDTH_B, RAM_BASE + RAM_BYTES, ~d, "past the end");
        end
        run_access(isa_pkg::OP_LOAD, isa_pkg::WIDTH_D, a, 64'd0, "reload after failed stores");
        // out-of-range stores would wrap onto the first and the last word
        run_access(isa_pkg::OP_LOAD, isa_pkg::WIDTH_D, RAM_BASE, 64'd0,
                   "first word after failed stores");
        run_access(isa_pkg::OP_LOAD, isa_pkg::WIDTH_D, RAM_BASE + RAM_BYTES - 64'd8, 64'd0,
                   "last word after failed stores");
    endtask

    task automatic backpressure_test();
        dmem_pkg::dmem_req_t a;
        dmem_pkg::dmem_req_t b;
        dmem_pkg::dmem_rsp_t want_a;
        dmem_pkg::dmem_rsp_t want_b;
        int                  stall;
        a = '{op: isa_pkg::OP_LOAD, width: isa_pkg::WIDTH_D, addr: RAM_BASE + 64'h10, wdata: '0};
        b = '{op: isa_pkg::OP_LOAD, width: isa_pkg::WIDTH_W, addr: RAM_BASE + 64'h0c, wdata: '0};
        model_access(a, want_a);
        model_access(b, want_b);
        stall     = int'($urandom_range(2, 8));
        rsp_ready = 1'b0;
        send_req(a);
        // b is offered while the response to a is stalled
        req       = b;
        req_valid = 1'b1;
        for (int i = 0; i <= stall; i++) begin
            check_rsp(rsp, want_a, "stalled response");
            check_ready(req_ready, 1'b0, "req_ready during the stall");
            if (i < stall) @(negedge clk);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        check_ready(rsp_valid, 1'b1, "rsp_valid for the request taken after the stall");
        check_rsp(rsp, want_b, "response after the stall");
        @(negedge clk);
        check_ready(rsp_valid, 1'b0, "rsp_valid once drained");
    endtask

    task automatic stream_test();
        dmem_pkg::dmem_req_t r    [3];
        dmem_pkg::dmem_rsp_t want [3];
        for (int i = 0; i < 3; i++) begin
            r[i] = '{op: isa_pkg::OP_LOAD, width: isa_pkg::WIDTH_D,
                     addr: RAM_BASE + 64'(i * 8), wdata: '0};
            model_access(r[i], want[i]);
        end
        check_ready(req_ready, 1'b1, "req_ready before the stream");
        req       = r[0];
        req_valid = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_ready(rsp_valid, 1'b1, "rsp_valid while streaming");
            check_ready(req_ready, 1'b1, "req_ready while streaming");
            check_rsp(rsp, want[i], "back-to-back response");
            if (i < 2) begin
                req = r[i+1];
            end else begin
                req_valid = 1'b0;
            end
        end
        @(negedge clk);
        check_ready(rsp_valid, 1'b0, "rsp_valid after the stream");
    endtask

    task automatic random_stream_test();
        isa_pkg::mem_width_e width;
        int                  idx;
        int                  off;
        for (int i = 0; i < 16; i++) begin
            run_access(isa_pkg::OP_STORE, isa_pkg::WIDTH_D, RAM_BASE + 64'(i * 8),
                       {$urandom, $urandom}, "random fill");
        end
        random_ready = 1'b1;
        for (int n = 0; n < 200; n++) begin
            width     = isa_pkg::mem_width_e'($urandom_range(0, 3));
            idx       = int'($urandom_range(0, 15));
            off       = int'($urandom_range(0, 7)) & ~(access_bytes(width) - 1);
            rsp_ready = 1'($urandom_range(0, 1));
            run_access(isa_pkg::mem_op_e'($urandom_range(0, 1)), width,
                       RAM_BASE + 64'(idx * 8 + off), {$urandom, $urandom}, "random access");
        end
        random_ready = 1'b0;
        rsp_ready    = 1'b1;
    endtask

    initial begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b1;
        random_ready = 1'b0;
        void'($urandom(81));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        reset_test();
        dword_test();
        narrow_test();
        error_test();
        backpressure_test();
        stream_test();
        random_stream_test();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
